// File: small_soc.f
hdl/bus_pkg.sv
hdl/board_pkg.sv
hdl/bus_decode.sv
hdl/word_ram.sv
hdl/vector_rom.sv
hdl/io_regs.sv
hdl/hex_display.sv
hdl/small_soc.sv
sim/small_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the small_soc testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module small_soc_tb -f small_soc.f
./obj_dir/Vsmall_soc_tb | tee sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: sim/small_soc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module small_soc_tb;

  localparam int RAM_WORDS   = 256;
  localparam int ROM_LATENCY = 3;
  localparam int AW          = $clog2(RAM_WORDS);
  localparam int NTBL        = 18;
  localparam int NRAND       = 40;
  localparam int RST_CYCLES  = 3;
  localparam int MAX_CYCLES  = (NTBL + NRAND) * 2 * 10 + RST_CYCLES;

  typedef struct packed {
    logic [31:0]    adr;
    logic [31:0]    dat;
    logic [3:0]     sel;
    logic           we;
    board_pkg::sw_t sw;
    logic [31:0]    exp_dat;
    logic           exp_fault;
  } entry_t;

  // hex digits 0..f, segments gfedcba active low
  localparam logic [6:0] SEG [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  localparam logic [31:0] ROM_TABLE [16] = '{
    32'h0000_0400, 32'h0000_0480, 32'h0000_0500, 32'h0000_0580,
    32'h0000_0600, 32'h0000_0680, 32'h0000_0700, 32'h0000_0780,
    32'h7000_0000, 32'h7000_0100, 32'h7000_0200, 32'h7000_0300,
    32'hc0de_0001, 32'hc0de_0002, 32'hdead_beef, 32'hffff_fffc
  };

  logic                                         sysclock;
  logic                                         rst_i;
  bus_pkg::bus_req_t                            bus_req;
  board_pkg::sw_t                               sw;
  bus_pkg::bus_rsp_t                            bus_rsp;
  board_pkg::led_t                              leds;
  logic                                         fault;
  board_pkg::seg7_t [board_pkg::NUM_DIGITS-1:0] hex;

  entry_t          tbl [NTBL];
  logic [31:0]     ref_mem [RAM_WORDS];
  logic [3:0]      ref_ok [RAM_WORDS];
  board_pkg::led_t ref_leds;
  int              errors;
  int              checks;
  int              cycle_cnt = 0;
  integer          seed;

  small_soc #(.RAM_WORDS(RAM_WORDS), .ROM_LATENCY(ROM_LATENCY)) small_soc_i (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .bus_req_i (bus_req),
    .sw_i      (sw),
    .bus_rsp_o (bus_rsp),
    .leds_o    (leds),
    .fault_o   (fault),
    .hex_o     (hex)
  );

  initial begin
    sysclock = 1'b0;
    forever #10 sysclock = ~sysclock;
  end

  always @(posedge sysclock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic int word_index(input logic [31:0] adr);
    return int'(adr[AW+1:2]);
  endfunction

  function automatic logic [27:0] expected_hex(input logic [31:0] adr);
    return {SEG[adr[31:28]], SEG[adr[11:8]], SEG[adr[7:4]], SEG[adr[3:0]]};
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // columns: adr, dat, sel, we, sw, exp_dat (i/o reads only), exp_fault
  task automatic fill_table();
    tbl[0]  = '{32'h0000_0010, 32'h1122_3344, 4'hf, 1'b1, 10'h000, 32'h0, 1'b0};
    tbl[1]  = '{32'h0000_0010, 32'haabb_ccdd, 4'h5, 1'b1, 10'h000, 32'h0, 1'b0};
    tbl[2]  = '{32'h0000_0010, 32'h0,         4'hf, 1'b0, 10'h000, 32'h0, 1'b0};
    // aliases word 4 of the ram
    tbl[3]  = '{32'h0000_0410, 32'h5566_7788, 4'h2, 1'b1, 10'h000, 32'h0, 1'b0};
    tbl[4]  = '{32'h0000_0010, 32'h0,         4'hf, 1'b0, 10'h000, 32'h0, 1'b0};
    tbl[5]  = '{32'h0000_0410, 32'h0,         4'hf, 1'b0, 10'h000, 32'h0, 1'b0};
    tbl[6]  = '{32'h0000_0020, 32'hcafe_f00d, 4'hf, 1'b1, 10'h000, 32'h0, 1'b0};
    tbl[7]  = '{32'hf000_0008, 32'h0,         4'hf, 1'b0, 10'h000, 32'h0, 1'b0};
    tbl[8]  = '{32'hf000_0038, 32'h1234_5678, 4'hf, 1'b1, 10'h000, 32'h0, 1'b0};
    tbl[9]  = '{32'hf000_0038, 32'h0,         4'hf, 1'b0, 10'h000, 32'h0, 1'b0};
    tbl[10] = '{32'h3000_0000, 32'h0,         4'hf, 1'b0, 10'h2a5, 32'h2a5, 1'b0};
    tbl[11] = '{32'h3000_0004, 32'h0000_0155, 4'h3, 1'b1, 10'h2a5, 32'h0, 1'b0};
    tbl[12] = '{32'h3000_0004, 32'h0,         4'hf, 1'b0, 10'h2a5, 32'h155, 1'b0};
    tbl[13] = '{32'h3000_0004, 32'h0000_02aa, 4'h2, 1'b1, 10'h2a5, 32'h0, 1'b0};
    tbl[14] = '{32'h3000_0004, 32'h0,         4'hf, 1'b0, 10'h2a5, 32'h255, 1'b0};
    tbl[15] = '{32'h3000_0010, 32'h0,         4'hf, 1'b0, 10'h2a5, 32'h0, 1'b1};
    tbl[16] = '{32'h3000_0000, 32'h0,         4'hf, 1'b0, 10'h00f, 32'h00f, 1'b1};
    tbl[17] = '{32'h0000_0020, 32'h0,         4'hf, 1'b0, 10'h00f, 32'h0, 1'b1};
  endtask

  task automatic transfer(input entry_t e);
    int          cycles;
    int          idx;
    logic [3:0]  region;
    logic [31:0] exp;
    logic [31:0] mask;
    cycles = 0;
    region = e.adr[31:28];
    idx    = word_index(e.adr);
    @(posedge sysclock);
    bus_req <= '{adr: e.adr, dat: e.dat, sel: e.sel, we: e.we, cyc: 1'b1, stb: 1'b1};
    sw      <= e.sw;
    // the next rising edge is the first to sample stb
    @(negedge sysclock);
    do begin
      @(negedge sysclock);
      cycles++;
    end while (!bus_rsp.ack);
    expect_eq(32'(hex), 32'(expected_hex(e.adr)), "hex digits");
    if (region == bus_pkg::REGION_VEC) begin
      expect_eq(32'(cycles), 32'(ROM_LATENCY), "rom ack latency");
    end else begin
      expect_eq(32'(cycles), 32'd1, "ack latency");
    end
    mask = '1;
    case (region)
      bus_pkg::REGION_VEC: exp = ROM_TABLE[e.adr[5:2]];
      bus_pkg::REGION_IO:  exp = e.exp_dat;
      default: begin
        exp  = ref_mem[idx];
        // bytes never written are not compared
        mask = {{8{ref_ok[idx][3]}}, {8{ref_ok[idx][2]}},
                {8{ref_ok[idx][1]}}, {8{ref_ok[idx][0]}}};
      end
    endcase
    if (!e.we) begin
      expect_eq(bus_rsp.dat & mask, exp & mask, "read data");
    end else if (region == bus_pkg::REGION_IO && e.adr[4:2] == 3'd1) begin
      if (e.sel[0]) ref_leds[7:0] = e.dat[7:0];
      if (e.sel[1]) ref_leds[9:8] = e.dat[9:8];
    end else if (region != bus_pkg::REGION_IO && region != bus_pkg::REGION_VEC) begin
      for (int b = 0; b < 4; b++) begin
        if (e.sel[b]) begin
          ref_mem[idx][8*b +: 8] = e.dat[8*b +: 8];
          ref_ok[idx][b] = 1'b1;
        end
      end
    end
    expect_eq(32'(leds), 32'(ref_leds), "leds");
    expect_eq(32'(fault), 32'(e.exp_fault), "fault flag");
    @(posedge sysclock);
    bus_req.cyc <= 1'b0;
    bus_req.stb <= 1'b0;
    @(negedge sysclock);
    expect_eq(32'(bus_rsp.ack), 32'd0, "ack after cycle end");
  endtask

  task automatic random_phase();
    entry_t      e;
    logic [31:0] r;
    for (int i = 0; i < NRAND; i++) begin
      e = '0;
      r = $random(seed);
      e.adr = {4'h0, r[27:2], 2'b00};
      e.dat = $random(seed);
      e.sel = 4'($random(seed));
      e.we  = 1'b1;
      e.exp_fault = 1'b1;
      transfer(e);
      r = $random(seed);
      // read the same word back through an aliased address
      e.adr = {4'h0, r[27:AW+2], e.adr[AW+1:2], 2'b00};
      e.we  = 1'b0;
      transfer(e);
    end
  endtask

  initial begin
    seed     = 32'h7965;
    errors   = 0;
    checks   = 0;
    rst_i    = 1'b1;
    bus_req  = '0;
    sw       = '0;
    ref_leds = '0;
    for (int i = 0; i < RAM_WORDS; i++) begin
      ref_mem[i] = '0;
      ref_ok[i]  = 4'h0;
    end
    fill_table();
    repeat (RST_CYCLES) @(posedge sysclock);
    rst_i <= 1'b0;
    @(negedge sysclock);
    expect_eq(32'(leds), 32'd0, "leds after reset");
    expect_eq(32'(fault), 32'd0, "fault after reset");
    expect_eq(32'(bus_rsp.ack), 32'd0, "ack after reset");
    foreach (tbl[i]) begin
      transfer(tbl[i]);
    end
    random_phase();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/small_soc.sv
`timescale 1ns/1ns
`default_nettype none

module small_soc #(
  parameter int RAM_WORDS   = 256,
  parameter int ROM_LATENCY = 3
) (
  input  wire                                         sysclock,
  input  wire                                         rst_i,
  input  wire bus_pkg::bus_req_t                      bus_req_i,
  input  wire board_pkg::sw_t                         sw_i,
  output bus_pkg::bus_rsp_t                           bus_rsp_o,
  output board_pkg::led_t                             leds_o,
  output logic                                        fault_o,
  output board_pkg::seg7_t [board_pkg::NUM_DIGITS-1:0] hex_o
);

  logic              ram_stb;
  logic              vec_stb;
  logic              io_stb;
  bus_pkg::bus_rsp_t ram_rsp;
  bus_pkg::bus_rsp_t vec_rsp;
  bus_pkg::bus_rsp_t io_rsp;

  bus_decode decode_i (
    .bus_req_i (bus_req_i),
    .ram_rsp_i (ram_rsp),
    .vec_rsp_i (vec_rsp),
    .io_rsp_i  (io_rsp),
    .ram_stb_o (ram_stb),
    .vec_stb_o (vec_stb),
    .io_stb_o  (io_stb),
    .bus_rsp_o (bus_rsp_o)
  );

  word_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .req_i    (bus_req_i),
    .stb_i    (ram_stb),
    .rsp_o    (ram_rsp)
  );

  vector_rom #(.ROM_LATENCY(ROM_LATENCY)) vec_i (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .req_i    (bus_req_i),
    .stb_i    (vec_stb),
    .rsp_o    (vec_rsp)
  );

  io_regs io_i (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .req_i    (bus_req_i),
    .stb_i    (io_stb),
    .sw_i     (sw_i),
    .rsp_o    (io_rsp),
    .leds_o   (leds_o),
    .fault_o  (fault_o)
  );

  hex_display hex_i (
    .adr_i (bus_req_i.adr),
    .hex_o (hex_o)
  );

endmodule

`default_nettype wire

// File: hdl/hex_display.sv
`timescale 1ns/1ns
`default_nettype none

module hex_display (
  input  wire [31:0]                                  adr_i,
  output board_pkg::seg7_t [board_pkg::NUM_DIGITS-1:0] hex_o
);

  logic [board_pkg::NUM_DIGITS-1:0][3:0] nib;

  function automatic board_pkg::seg7_t to_seg(input logic [3:0] val);
    case (val)
      4'h0: to_seg = 7'h40;
      4'h1: to_seg = 7'h79;
      4'h2: to_seg = 7'h24;
      4'h3: to_seg = 7'h30;
      4'h4: to_seg = 7'h19;
      4'h5: to_seg = 7'h12;
      4'h6: to_seg = 7'h02;
      4'h7: to_seg = 7'h78;
      4'h8: to_seg = 7'h00;
      4'h9: to_seg = 7'h10;
      4'ha: to_seg = 7'h08;
      4'hb: to_seg = 7'h03;
      4'hc: to_seg = 7'h46;
      4'hd: to_seg = 7'h21;
      4'he: to_seg = 7'h06;
      default: to_seg = 7'h0e;
    endcase
  endfunction

  // region nibble on the left, low 12 bits on the right
  assign nib = {adr_i[31:28], adr_i[11:8], adr_i[7:4], adr_i[3:0]};

  for (genvar d = 0; d < board_pkg::NUM_DIGITS; d++) begin : g_digit
    assign hex_o[d] = to_seg(nib[d]);
  end

endmodule

`default_nettype wire

// File: hdl/io_regs.sv
`timescale 1ns/1ns
`default_nettype none

module io_regs (
  input  wire                    sysclock,
  input  wire                    rst_i,
  input  wire bus_pkg::bus_req_t req_i,
  input  wire                    stb_i,
  input  wire board_pkg::sw_t    sw_i,
  output bus_pkg::bus_rsp_t      rsp_o,
  output board_pkg::led_t        leds_o,
  output logic                   fault_o
);

  localparam logic [2:0] OFS_SW  = 3'd0;
  localparam logic [2:0] OFS_LED = 3'd1;

  logic [2:0]      ofs;
  logic            ack;
  logic            start;
  logic            fault_q;
  logic [31:0]     rdata;
  board_pkg::led_t leds_q;

  assign ofs   = req_i.adr[4:2];
  assign start = stb_i & ~ack;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack     <= 1'b0;
      leds_q  <= '0;
      fault_q <= 1'b0;
    end else if (!req_i.cyc) begin
      ack <= 1'b0;
    end else begin
      ack <= start;
      if (start) begin
        case (ofs)
          OFS_SW: begin
            // switches are read only
          end
          OFS_LED: begin
            if (req_i.we && req_i.sel[0]) begin
              leds_q[7:0] <= req_i.dat[7:0];
            end
            if (req_i.we && req_i.sel[1]) begin
              leds_q[9:8] <= req_i.dat[9:8];
            end
          end
          // unmapped offset, sticky until reset
          default: fault_q <= 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (start) begin
      case (ofs)
        OFS_SW:  rdata <= 32'(sw_i);
        OFS_LED: rdata <= 32'(leds_q);
        default: rdata <= '0;
      endcase
    end
  end

  assign rsp_o.dat = rdata;
  assign rsp_o.ack = ack;
  assign leds_o    = leds_q;
  assign fault_o   = fault_q;

  // master ends the cycle right after ack
  assert property (@(posedge sysclock) disable iff (rst_i) ack |=> !req_i.cyc)
    else $error("io_regs: cyc still high one cycle after ack");

endmodule

`default_nettype wire

// File: hdl/vector_rom.sv
`timescale 1ns/1ns
`default_nettype none

module vector_rom #(
  parameter int ROM_LATENCY = 3
) (
  input  wire                    sysclock,
  input  wire                    rst_i,
  input  wire bus_pkg::bus_req_t req_i,
  input  wire                    stb_i,
  output bus_pkg::bus_rsp_t      rsp_o
);

  localparam logic [31:0] VECTORS [16] = '{
    32'h0000_0400, 32'h0000_0480, 32'h0000_0500, 32'h0000_0580,
    32'h0000_0600, 32'h0000_0680, 32'h0000_0700, 32'h0000_0780,
    32'h7000_0000, 32'h7000_0100, 32'h7000_0200, 32'h7000_0300,
    32'hc0de_0001, 32'hc0de_0002, 32'hdead_beef, 32'hffff_fffc
  };

  logic [ROM_LATENCY-1:0] sr;
  logic                   busy;
  logic                   launch;

  // one pulse per transfer, then wait for cyc to drop
  assign launch = stb_i & ~busy;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      sr   <= '0;
      busy <= 1'b0;
    end else if (!req_i.cyc) begin
      sr   <= '0;
      busy <= 1'b0;
    end else begin
      sr <= (sr << 1) | ROM_LATENCY'(launch);
      if (launch) begin
        busy <= 1'b1;
      end
    end
  end

  // writes fall through, table is constant
  assign rsp_o.dat = VECTORS[req_i.adr[5:2]];
  assign rsp_o.ack = sr[ROM_LATENCY-1];

  assert property (@(posedge sysclock) disable iff (rst_i)
    launch |-> ##ROM_LATENCY rsp_o.ack)
    else $error("vector_rom: ack not after ROM_LATENCY edges");

endmodule

`default_nettype wire

// File: hdl/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

module word_ram #(
  parameter int RAM_WORDS = 256
) (
  input  wire                    sysclock,
  input  wire                    rst_i,
  input  wire bus_pkg::bus_req_t req_i,
  input  wire                    stb_i,
  output bus_pkg::bus_rsp_t      rsp_o
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [31:0]   rdata;
  logic          ack;
  logic          start;
  logic [AW-1:0] idx;

  // upper address bits alias
  assign idx   = req_i.adr[AW+1:2];
  assign start = stb_i & ~ack;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack <= 1'b0;
    end else if (!req_i.cyc) begin
      ack <= 1'b0;
    end else begin
      ack <= start;
    end
  end

  always_ff @(posedge sysclock) begin
    if (start) begin
      rdata <= mem[idx];
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) begin
            mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp_o.dat = rdata;
  assign rsp_o.ack = ack;

  // master holds the request until ack
  assert property (@(posedge sysclock) disable iff (rst_i)
    stb_i && !ack |=> stb_i && $stable(req_i))
    else $error("word_ram: request changed or dropped before ack");

endmodule

`default_nettype wire

// File: hdl/bus_decode.sv
`timescale 1ns/1ns
`default_nettype none

module bus_decode (
  input  wire bus_pkg::bus_req_t bus_req_i,
  input  wire bus_pkg::bus_rsp_t ram_rsp_i,
  input  wire bus_pkg::bus_rsp_t vec_rsp_i,
  input  wire bus_pkg::bus_rsp_t io_rsp_i,
  output logic                   ram_stb_o,
  output logic                   vec_stb_o,
  output logic                   io_stb_o,
  output bus_pkg::bus_rsp_t      bus_rsp_o
);

  logic       active;
  logic [3:0] region;

  assign active = bus_req_i.cyc & bus_req_i.stb;
  assign region = bus_req_i.adr[31:28];

  always_comb begin
    ram_stb_o = 1'b0;
    vec_stb_o = 1'b0;
    io_stb_o  = 1'b0;
    case (region)
      bus_pkg::REGION_IO: begin
        io_stb_o  = active;
        bus_rsp_o = io_rsp_i;
      end
      bus_pkg::REGION_VEC: begin
        vec_stb_o = active;
        bus_rsp_o = vec_rsp_i;
      end
      // everything else lands in the RAM
      default: begin
        ram_stb_o = active;
        bus_rsp_o = ram_rsp_i;
      end
    endcase
  end

  // only the addressed slave may answer
  always_comb begin
    assert (!(io_rsp_i.ack && region != bus_pkg::REGION_IO) &&
            !(vec_rsp_i.ack && region != bus_pkg::REGION_VEC) &&
            !(ram_rsp_i.ack && (region == bus_pkg::REGION_IO ||
                                region == bus_pkg::REGION_VEC)))
      else $error("bus_decode: ack from a slave that is not addressed");
  end

endmodule

`default_nettype wire

// File: hdl/board_pkg.sv
`default_nettype none

package board_pkg;

  localparam int NUM_DIGITS = 4;

  typedef logic [9:0] sw_t;
  typedef logic [9:0] led_t;

  // segments g..a, active low
  typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

// File: hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // master request, held stable until ack
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } bus_req_t;

  // slave response, dat valid while ack is high
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } bus_rsp_t;

  // address bits 31:28
  localparam logic [3:0] REGION_IO  = 4'h3;
  localparam logic [3:0] REGION_VEC = 4'hf;

endpackage

`default_nettype wire
